//--- hw/cart_io_macros.svh
/*
 * Build constants of the I/O cartridge core.
 * The port base must sit on an 8-port boundary. Each channel takes two ports.
 * A FIFO depth above 15 no longer fits the 4-bit fill count of the status byte.
 */
`ifndef CART_IO_MACROS_SVH
`define CART_IO_MACROS_SVH

// ----------------------------------------------------------------------
// slot decode
// ----------------------------------------------------------------------
`define CART_IO_BASE		8'h40	// first decoded i/o port, data port of channel 0

// ----------------------------------------------------------------------
// mailbox sizing
// ----------------------------------------------------------------------
`define CART_NUM_CHANNELS	4		// data + status port each
`define CART_FIFO_DEPTH		8		// bytes per mailbox
`define CART_REQ_DEPTH		2		// front end queue, one read plus one write

`endif

//--- hw/cart_io_pkg.sv
/*
 * Types shared by the slot front end, the mailboxes and the merger.
 * The request carries the channel index, so the channel count is capped at
 * four by the width of the index type.
 */
package cart_io_pkg;

	// ----------------------------------------------------------------------
	// internal bus
	// ----------------------------------------------------------------------
	typedef logic [1:0] chan_idx_t;		// mailbox select

	typedef struct packed {
		chan_idx_t	chan;			// target mailbox
		logic		is_status;		// odd port, status/control
		logic		write;			// host write when set
		logic [7:0]	wdata;			// don't care for reads
	} bus_req_t;

	typedef struct packed {
		logic [7:0]	rdata;
		logic		rdata_en;		// one-cycle strobe, qualifies rdata
	} bus_rsp_t;

	// ----------------------------------------------------------------------
	// status byte of a mailbox
	// ----------------------------------------------------------------------
	localparam int STAT_IE_BIT		= 7;	// interrupt enable, also the write bit
	localparam int STAT_FULL_BIT	= 6;
	localparam int STAT_EMPTY_BIT	= 5;
	localparam int STAT_COUNT_MSB	= 3;	// bit 4 reads as zero
	localparam int STAT_COUNT_LSB	= 0;

endpackage

//--- hw/sync_fifo.sv
/*
 * Single-clock FIFO with first-word fall-through.
 * rdata shows the head entry whenever empty is low, and pop removes it.
 * A push while full is dropped and a pop while empty is ignored.
 * DEPTH must be 2 or more.
 */
`timescale 1ns/1ps

module sync_fifo #(
	parameter type	payload_t	= logic [7:0],
	parameter int	DEPTH		= 8
) (
	input	logic						clk85m,
	input	logic						rst,
	input	logic						push,
	input	payload_t					wdata,
	input	logic						pop,
	output	payload_t					rdata,
	output	logic						empty,
	output	logic						full,
	output	logic [$clog2(DEPTH+1)-1:0]	count
);
	localparam int AW = $clog2(DEPTH);		// pointer width
	localparam int CW = $clog2(DEPTH + 1);	// occupancy width, counts up to DEPTH

	payload_t		mem [DEPTH];			// storage, no reset
	logic [AW-1:0]	wr_ptr;
	logic [AW-1:0]	rd_ptr;
	logic			do_push;
	logic			do_pop;

	// wrap at DEPTH, which need not be a power of two
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_push	= push && !full;		// overflow lost
	assign do_pop	= pop && !empty;
	assign empty	= (count == '0);
	assign full		= (count == CW'(DEPTH));
	assign rdata	= mem[rd_ptr];			// head visible in the pop cycle

	always_ff @(posedge clk85m) begin
		if (rst) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	;						// both or neither, level unchanged
			endcase
		end
	end

	always_ff @(posedge clk85m) begin
		if (do_push) begin
			mem[wr_ptr] <= wdata;
		end
	end

endmodule

//--- hw/slot_frontend.sv
/*
 * Slot side of the core. iorq_n, rd_n and wr_n pass a two-flop synchronizer.
 * slot_a and slot_d_in are taken unsynchronized at the detected edge, so the
 * host holds them stable while its strobe is low and honors slot_wait.
 * Only the eight ports from the base are decoded and all others are ignored.
 * A read completes 6 clocks after the pin edge when the queue is empty.
 */
`timescale 1ns/1ps
`include "cart_io_macros.svh"

module slot_frontend (
	input	logic							clk85m,
	input	logic							rst,
	input	logic							slot_iorq_n,
	input	logic							slot_rd_n,
	input	logic							slot_wr_n,
	input	logic [7:0]						slot_a,
	input	logic [7:0]						slot_d_in,
	input	cart_io_pkg::bus_rsp_t			rsp,		// merged read response
	output	logic							slot_wait,
	output	logic [7:0]						slot_d_out,
	output	logic							slot_d_oe,
	output	logic [`CART_NUM_CHANNELS-1:0]	req_valid,	// one-hot, one cycle
	output	cart_io_pkg::bus_req_t			req
);
	import cart_io_pkg::*;

	logic		iorq_meta;		// first sync stage
	logic		rd_meta;
	logic		wr_meta;
	logic		iorq_sync;		// second sync stage
	logic		rd_sync;
	logic		wr_sync;
	logic		rd_prev;		// for edge detect
	logic		wr_prev;

	logic [7:0]	port_ofs;
	logic		in_range;
	logic		rd_start;
	logic		wr_start;
	logic		capture;
	bus_req_t	new_req;

	bus_req_t	q_head;
	logic		q_empty;
	logic		q_pop;

	logic		rd_pending;		// read waiting for its response
	logic		wr_pending;		// write still in the queue
	logic		d_oe_q;

	// ----------------------------------------------------------------------
	// strobe synchronizer and edge detect
	// ----------------------------------------------------------------------
	always_ff @(posedge clk85m) begin
		if (rst) begin
			iorq_meta	<= 1'b1;		// strobes idle high
			rd_meta		<= 1'b1;
			wr_meta		<= 1'b1;
			iorq_sync	<= 1'b1;
			rd_sync		<= 1'b1;
			wr_sync		<= 1'b1;
			rd_prev		<= 1'b1;
			wr_prev		<= 1'b1;
		end else begin
			iorq_meta	<= slot_iorq_n;
			rd_meta		<= slot_rd_n;
			wr_meta		<= slot_wr_n;
			iorq_sync	<= iorq_meta;
			rd_sync		<= rd_meta;
			wr_sync		<= wr_meta;
			rd_prev		<= rd_sync;
			wr_prev		<= wr_sync;
		end
	end

	assign rd_start	= !iorq_sync && !rd_sync && rd_prev;	// falling rd_n inside iorq
	assign wr_start	= !iorq_sync && !wr_sync && wr_prev;

	// ----------------------------------------------------------------------
	// port decode and request build
	// ----------------------------------------------------------------------
	assign port_ofs	= slot_a - `CART_IO_BASE;			// wraps below base, fails range
	assign in_range	= (port_ofs < 8'(2 * `CART_NUM_CHANNELS));
	assign capture	= (rd_start || wr_start) && in_range;

	always_comb begin
		new_req.chan		= port_ofs[2:1];	// two ports per channel
		new_req.is_status	= port_ofs[0];		// odd port
		new_req.write		= !rd_start;		// rd wins if both strobes fall
		new_req.wdata		= slot_d_in;
	end

	// ----------------------------------------------------------------------
	// request queue and dispatch
	// ----------------------------------------------------------------------
	sync_fifo #(
		.payload_t	(bus_req_t),
		.DEPTH		(`CART_REQ_DEPTH)
	) u_req_q (
		.clk85m		(clk85m),
		.rst		(rst),
		.push		(capture),
		.wdata		(new_req),
		.pop		(q_pop),
		.rdata		(q_head),
		.empty		(q_empty),
		.full		(),					// host waits, queue never overflows
		.count		()
	);

	assign q_pop	= !q_empty;			// channels take a request every cycle
	assign req		= q_head;

	always_comb begin
		req_valid = '0;
		if (!q_empty) begin
			req_valid[q_head.chan] = 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// wait generation and read data latch
	// ----------------------------------------------------------------------
	always_ff @(posedge clk85m) begin
		if (rst) begin
			rd_pending	<= 1'b0;
			wr_pending	<= 1'b0;
			d_oe_q		<= 1'b0;
		end else begin
			if (capture && rd_start)
				rd_pending <= 1'b1;
			else if (rsp.rdata_en)
				rd_pending <= 1'b0;				// data arrives this cycle

			if (capture && !rd_start)
				wr_pending <= 1'b1;
			else if (q_pop && q_head.write)
				wr_pending <= 1'b0;				// write handed to its channel

			if (rsp.rdata_en && rd_pending)
				d_oe_q <= 1'b1;
			else if (rd_sync)
				d_oe_q <= 1'b0;					// host released rd_n
		end
	end

	always_ff @(posedge clk85m) begin
		if (rsp.rdata_en && rd_pending) begin
			slot_d_out <= rsp.rdata;			// held for the rest of the cycle
		end
	end

	assign slot_wait	= rd_pending || wr_pending;
	assign slot_d_oe	= d_oe_q && !rd_sync;		// drop at once on rd_n release

endmodule

//--- hw/mailbox_channel.sv
/*
 * One mailbox. The data port pushes to and pops from a byte FIFO, and the
 * status port reads flags and fill count and writes the interrupt enable.
 * A write to a full mailbox is lost and a read of an empty one gives 8'hFF.
 * The response comes one cycle after the request.
 */
`timescale 1ns/1ps
`include "cart_io_macros.svh"

module mailbox_channel (
	input	logic					clk85m,
	input	logic					rst,
	input	logic					req_valid,		// one-cycle strobe
	input	cart_io_pkg::bus_req_t	req,
	output	cart_io_pkg::bus_rsp_t	rsp,
	output	logic					irq_pending
);
	import cart_io_pkg::*;

	localparam int CNT_W = $clog2(`CART_FIFO_DEPTH + 1);

	logic				push;
	logic				pop;
	logic				stat_wr;
	logic				rd_req;
	logic [7:0]			fifo_rdata;
	logic				fifo_empty;
	logic				fifo_full;
	logic [CNT_W-1:0]	fifo_count;
	logic [7:0]			status;
	logic				irq_en;
	logic [7:0]			rdata_q;
	logic				rdata_en_q;

	// ----------------------------------------------------------------------
	// request split
	// ----------------------------------------------------------------------
	assign push		= req_valid && req.write && !req.is_status;
	assign pop		= req_valid && !req.write && !req.is_status;
	assign stat_wr	= req_valid && req.write && req.is_status;
	assign rd_req	= req_valid && !req.write;		// data or status read

	sync_fifo #(
		.payload_t	(logic [7:0]),
		.DEPTH		(`CART_FIFO_DEPTH)
	) u_fifo (
		.clk85m		(clk85m),
		.rst		(rst),
		.push		(push),
		.wdata		(req.wdata),
		.pop		(pop),
		.rdata		(fifo_rdata),
		.empty		(fifo_empty),
		.full		(fifo_full),
		.count		(fifo_count)
	);

	always_comb begin
		status									= '0;
		status[STAT_IE_BIT]						= irq_en;
		status[STAT_FULL_BIT]					= fifo_full;
		status[STAT_EMPTY_BIT]					= fifo_empty;
		status[STAT_COUNT_MSB:STAT_COUNT_LSB]	= fifo_count;
	end

	// ----------------------------------------------------------------------
	// interrupt enable and read response
	// ----------------------------------------------------------------------
	always_ff @(posedge clk85m) begin
		if (rst) begin
			irq_en		<= 1'b0;
			rdata_en_q	<= 1'b0;
		end else begin
			rdata_en_q	<= rd_req;
			if (stat_wr)
				irq_en <= req.wdata[STAT_IE_BIT];
		end
	end

	always_ff @(posedge clk85m) begin
		if (rd_req) begin
			if (req.is_status)
				rdata_q <= status;
			else if (fifo_empty)
				rdata_q <= 8'hFF;				// nothing to pop
			else
				rdata_q <= fifo_rdata;			// head, popped in this cycle
		end
	end

	assign rsp			= '{rdata: rdata_q, rdata_en: rdata_en_q};
	assign irq_pending	= irq_en && !fifo_empty;

endmodule

//--- hw/read_merger.sv
/*
 * Merges the channel read responses. Only one channel may answer in a
 * cycle, which holds while the front end dispatches one request per cycle.
 * Response and interrupt each leave through one register stage.
 */
`timescale 1ns/1ps
`include "cart_io_macros.svh"

module read_merger (
	input	logic							clk85m,
	input	logic							rst,
	input	cart_io_pkg::bus_rsp_t			ch_rsp [`CART_NUM_CHANNELS],
	input	logic [`CART_NUM_CHANNELS-1:0]	ch_irq,
	output	cart_io_pkg::bus_rsp_t			rsp,
	output	logic							slot_intr
);
	import cart_io_pkg::*;

	bus_rsp_t						merged;
	logic [`CART_NUM_CHANNELS-1:0]	en_vec;		// per-channel strobes
	logic [7:0]						rdata_q;
	logic							rdata_en_q;

	always_comb begin
		merged = '0;
		for (int i = 0; i < `CART_NUM_CHANNELS; i++) begin
			en_vec[i]		= ch_rsp[i].rdata_en;
			merged.rdata_en	= merged.rdata_en | ch_rsp[i].rdata_en;
			merged.rdata	= merged.rdata | (ch_rsp[i].rdata & {8{ch_rsp[i].rdata_en}});
		end
	end

	always_ff @(posedge clk85m) begin
		if (rst) begin
			rdata_en_q	<= 1'b0;
			slot_intr	<= 1'b0;
		end else begin
			rdata_en_q	<= merged.rdata_en;
			slot_intr	<= |ch_irq;				// any enabled mailbox with data
			assert ($countones(en_vec) <= 1)
				else $error("read_merger: %0d channels answered together",
					$countones(en_vec));
		end
	end

	always_ff @(posedge clk85m) begin
		rdata_q <= merged.rdata;
	end

	assign rsp = '{rdata: rdata_q, rdata_en: rdata_en_q};

endmodule

//--- hw/cart_io_top.sv
/*
 * I/O cartridge core for one slot, four mailboxes behind eight ports.
 * The bidirectional data pad sits outside and uses slot_d_in, slot_d_out and
 * slot_d_oe. rst is synchronous to clk85m and active high, and clock and
 * reset generation are outside this core.
 */
`timescale 1ns/1ps
`include "cart_io_macros.svh"

module cart_io_top (
	input	logic			clk85m,			// 85.9 MHz
	input	logic			rst,
	input	logic			slot_iorq_n,
	input	logic			slot_rd_n,
	input	logic			slot_wr_n,
	input	logic [7:0]		slot_a,
	input	logic [7:0]		slot_d_in,
	output	logic			slot_wait,
	output	logic [7:0]		slot_d_out,
	output	logic			slot_d_oe,		// pad drive enable
	output	logic			slot_intr
);
	import cart_io_pkg::*;

	logic [`CART_NUM_CHANNELS-1:0]	req_valid;
	bus_req_t						req;		// shared by all channels
	bus_rsp_t						ch_rsp [`CART_NUM_CHANNELS];
	logic [`CART_NUM_CHANNELS-1:0]	ch_irq;
	bus_rsp_t						mrg_rsp;

	// ----------------------------------------------------------------------
	// slot front end
	// ----------------------------------------------------------------------
	slot_frontend u_frontend (
		.clk85m			(clk85m),
		.rst			(rst),
		.slot_iorq_n	(slot_iorq_n),
		.slot_rd_n		(slot_rd_n),
		.slot_wr_n		(slot_wr_n),
		.slot_a			(slot_a),
		.slot_d_in		(slot_d_in),
		.rsp			(mrg_rsp),
		.slot_wait		(slot_wait),
		.slot_d_out		(slot_d_out),
		.slot_d_oe		(slot_d_oe),
		.req_valid		(req_valid),
		.req			(req)
	);

	// ----------------------------------------------------------------------
	// mailboxes
	// ----------------------------------------------------------------------
	for (genvar i = 0; i < `CART_NUM_CHANNELS; i++) begin : gen_chan
		mailbox_channel u_chan (
			.clk85m			(clk85m),
			.rst			(rst),
			.req_valid		(req_valid[i]),
			.req			(req),
			.rsp			(ch_rsp[i]),
			.irq_pending	(ch_irq[i])
		);
	end

	read_merger u_merger (
		.clk85m			(clk85m),
		.rst			(rst),
		.ch_rsp			(ch_rsp),
		.ch_irq			(ch_irq),
		.rsp			(mrg_rsp),
		.slot_intr		(slot_intr)
	);

endmodule

//--- test/cart_io_assertions.sv
/*
 * Slot protocol checks on cart_io_top, attached by bind.
 * rd_n is resynchronized here with two flops that match the front end, so
 * the output enable rule sees the same synchronized strobe as the DUT.
 */
`timescale 1ns/1ps

module cart_io_assertions (
	input	logic	clk85m,
	input	logic	rst,
	input	logic	slot_rd_n,
	input	logic	slot_wait,
	input	logic	slot_d_oe,
	input	logic	slot_intr
);
	logic		rd_meta;
	logic		rd_sync;			// same stage as the front end
	logic [5:0]	wait_cnt;			// cycles with wait high, saturates

	always_ff @(posedge clk85m) begin
		if (rst) begin
			rd_meta	<= 1'b1;		// strobe idles high
			rd_sync	<= 1'b1;
		end else begin
			rd_meta	<= slot_rd_n;
			rd_sync	<= rd_meta;
		end
	end

	always_ff @(posedge clk85m) begin
		if (rst || !slot_wait) begin
			wait_cnt <= '0;
		end else if (wait_cnt != 6'h3f) begin
			wait_cnt <= wait_cnt + 6'd1;
		end
	end

	// ----------------------------------------------------------------------
	// slot rules
	// ----------------------------------------------------------------------
	a_oe_in_read: assert property (@(posedge clk85m) disable iff (rst)
		!(slot_d_oe && rd_sync))
		else $error("slot_d_oe high while synchronized rd_n is high");

	a_wait_bound: assert property (@(posedge clk85m) disable iff (rst)
		wait_cnt <= 6'd32)
		else $error("slot_wait held high for more than 32 cycles");

	a_intr_known: assert property (@(posedge clk85m) disable iff (rst)
		!$isunknown(slot_intr))
		else $error("slot_intr unknown after reset");

endmodule

bind cart_io_top cart_io_assertions u_assertions (
	.clk85m		(clk85m),
	.rst		(rst),
	.slot_rd_n	(slot_rd_n),
	.slot_wait	(slot_wait),
	.slot_d_oe	(slot_d_oe),
	.slot_intr	(slot_intr)
);

//--- test/cart_io_tb.sv
/*
 * Random slot accesses against a mailbox model, seeded for repeatable runs.
 * The host side honors slot_wait and holds address and data while a strobe
 * is low. Read data of ports outside the eight decoded ones is not checked.
 */
`timescale 1ns/1ps
`include "cart_io_macros.svh"

module cart_io_tb;

	localparam int NUM_CH		= `CART_NUM_CHANNELS;
	localparam int FIFO_DEPTH	= `CART_FIFO_DEPTH;
	localparam int NUM_ACCESS	= 400;
	localparam int RISE_LIMIT	= 16;		// cycles until wait must rise
	localparam int FALL_LIMIT	= 64;		// cycles until wait must fall

	logic		clk85m;
	logic		rst;
	logic		slot_iorq_n;
	logic		slot_rd_n;
	logic		slot_wr_n;
	logic [7:0]	slot_a;
	logic [7:0]	slot_d_in;
	logic		slot_wait;
	logic [7:0]	slot_d_out;
	logic		slot_d_oe;
	logic		slot_intr;

	integer		seed;
	int			n_checks;
	int			n_errors;
	bit			timed_out;				// stops the access loop
	logic [7:0]	model_q [NUM_CH][$];	// bytes held per mailbox
	logic		model_ie [NUM_CH];		// interrupt enable per mailbox

	cart_io_top cart_io_top_inst (
		.clk85m			(clk85m),
		.rst			(rst),
		.slot_iorq_n	(slot_iorq_n),
		.slot_rd_n		(slot_rd_n),
		.slot_wr_n		(slot_wr_n),
		.slot_a			(slot_a),
		.slot_d_in		(slot_d_in),
		.slot_wait		(slot_wait),
		.slot_d_out		(slot_d_out),
		.slot_d_oe		(slot_d_oe),
		.slot_intr		(slot_intr)
	);

	always #10 clk85m = ~clk85m;		// 20 ns period

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		n_checks++;
		assert (got === exp) else begin
			$display("** Error: %s = 0x%02h, expected 0x%02h", name, got, exp);
			n_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		n_checks++;
		assert (got === exp) else begin
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
			n_errors++;
		end
	endtask

	// polls slot_wait on falling edges, gives up after limit cycles
	task automatic wait_for_level(input logic level, input int limit, output bit ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < limit) begin
			@(negedge clk85m);
			ok = (slot_wait === level);
			cycles++;
		end
	endtask

	// ----------------------------------------------------------------------
	// one host i/o cycle
	// ----------------------------------------------------------------------
	task automatic slot_access(input logic [7:0] port, input logic wr,
			input logic [7:0] data, output logic [7:0] rdata);
		bit			ok;
		logic [7:0]	ofs;
		ofs = port - `CART_IO_BASE;				// wraps below base
		rdata = 8'h00;
		@(negedge clk85m);
		slot_a		= port;
		slot_d_in	= data;
		slot_iorq_n	= 1'b0;
		slot_rd_n	= wr;
		slot_wr_n	= !wr;
		if (ofs < 8'd8) begin
			wait_for_level(1'b1, RISE_LIMIT, ok);
			if (!ok) begin
				$display("timeout: slot_wait never rose for port 0x%02h", port);
				n_errors++;
				timed_out = 1'b1;
			end else begin
				wait_for_level(1'b0, FALL_LIMIT, ok);
				if (!ok) begin
					$display("timeout: slot_wait stuck high for port 0x%02h", port);
					n_errors++;
					timed_out = 1'b1;
				end else if (!wr) begin
					check_bit("slot_d_oe", slot_d_oe, 1'b1);	// rises with wait fall
					rdata = slot_d_out;
				end
			end
		end else begin
			repeat (8) begin						// ignored port, watch outputs
				@(negedge clk85m);
				check_bit("slot_wait", slot_wait, 1'b0);
				check_bit("slot_d_oe", slot_d_oe, 1'b0);
			end
		end
		@(negedge clk85m);
		slot_iorq_n	= 1'b1;
		slot_rd_n	= 1'b1;
		slot_wr_n	= 1'b1;
		repeat (3) @(negedge clk85m);				// idle gap, lets intr settle
	endtask

	// ----------------------------------------------------------------------
	// mailbox model
	// ----------------------------------------------------------------------
	task automatic model_check(input logic [7:0] port, input logic wr,
			input logic [7:0] data, input logic [7:0] got);
		logic [7:0]	ofs;
		logic [7:0]	exp;
		int			ch;
		int			n;
		ofs = port - `CART_IO_BASE;
		if (ofs < 8'd8) begin
			ch = int'(ofs[2:1]);					// two ports per mailbox
			n = model_q[ch].size();
			if (!ofs[0] && wr) begin
				if (n < FIFO_DEPTH)
					model_q[ch].push_back(data);	// full mailbox drops it
			end else if (!ofs[0]) begin
				if (n == 0)
					exp = 8'hFF;
				else
					exp = model_q[ch].pop_front();
				check_byte("slot_d_out", got, exp);
			end else if (wr) begin
				model_ie[ch] = data[7];
			end else begin
				exp = {model_ie[ch], n == FIFO_DEPTH, n == 0, 1'b0, 4'(n)};
				check_byte("slot_d_out", got, exp);
			end
		end
	endtask

	function automatic logic model_intr();
		logic any;
		any = 1'b0;
		for (int i = 0; i < NUM_CH; i++) begin
			any = any | (model_ie[i] && model_q[i].size() != 0);
		end
		return any;
	endfunction

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	initial begin
		logic [31:0]	rnd;
		logic [7:0]		port;
		logic			wr;
		logic [7:0]		data;
		logic [7:0]		rdata;
		seed		= 32'hc83a889c;
		n_checks	= 0;
		n_errors	= 0;
		timed_out	= 1'b0;
		clk85m		= 1'b0;
		rst			= 1'b1;
		slot_iorq_n	= 1'b1;
		slot_rd_n	= 1'b1;
		slot_wr_n	= 1'b1;
		slot_a		= 8'h00;
		slot_d_in	= 8'h00;
		for (int i = 0; i < NUM_CH; i++) begin
			model_ie[i] = 1'b0;
		end

		repeat (2) begin								// reset for 2 cycles
			@(negedge clk85m);
			check_bit("slot_wait", slot_wait, 1'b0);
			check_bit("slot_d_oe", slot_d_oe, 1'b0);
			check_bit("slot_intr", slot_intr, 1'b0);
		end
		rst = 1'b0;
		@(negedge clk85m);
		check_bit("slot_wait", slot_wait, 1'b0);
		check_bit("slot_d_oe", slot_d_oe, 1'b0);
		check_bit("slot_intr", slot_intr, 1'b0);

		for (int c = 0; c < NUM_CH && !timed_out; c++) begin	// status after reset
			port = `CART_IO_BASE + 8'(2 * c + 1);
			slot_access(port, 1'b0, 8'h00, rdata);
			check_bit("status empty", rdata[5], 1'b1);
			check_bit("status enable", rdata[7], 1'b0);
			model_check(port, 1'b0, 8'h00, rdata);
		end

		for (int i = 0; i < NUM_ACCESS && !timed_out; i++) begin
			rnd = $random(seed);
			if (rnd % 100 < 80) begin					// decoded port
				rnd = $random(seed);
				port = `CART_IO_BASE + {5'd0, rnd[2:0]};
			end else begin
				do begin
					rnd = $random(seed);
					port = rnd[7:0];
				end while (port - `CART_IO_BASE < 8'd8);
			end
			rnd = $random(seed);
			wr = (rnd % 100 < 60);						// lean to writes, reaches full
			rnd = $random(seed);
			data = rnd[7:0];
			slot_access(port, wr, data, rdata);
			if (!timed_out) begin
				model_check(port, wr, data, rdata);
				check_bit("slot_intr", slot_intr, model_intr());
			end
		end

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- cart_io.f
+incdir+hw
hw/cart_io_pkg.sv
hw/sync_fifo.sv
hw/slot_frontend.sv
hw/mailbox_channel.sv
hw/read_merger.sv
hw/cart_io_top.sv
test/cart_io_assertions.sv
test/cart_io_tb.sv

//--- Makefile
# Verilator flow for the cart_io core
# make lint   static check of RTL and testbench
# make sim    build and run, fails if the log shows a failure
# make clean  remove build products and log

TOP = cart_io_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f cart_io.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f cart_io.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "sim failed" sim.log; then \
		echo "FAIL: testbench reported errors"; \
		exit 1; \
	fi
	@if ! grep -q "sim passed" sim.log; then \
		echo "FAIL: simulation stopped before its report"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
